// File: build.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/fetch_stage.sv
verilog/instr_queue.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/core_top.sv
verification/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the core testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module core_tb -o core_tb \
    && ./obj_dir/core_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }

// File: verification/core_tb.sv
/*
 * core testbench
 * random RV32I subset programs run on core_top against a reference model,
 * Wishbone memories with random wait states on both buses
 */

`timescale 1ns/10ps

module core_tb;

    localparam int N_TESTS     = 6;
    localparam int N_RAND      = 40;
    localparam int PROG_LEN    = 61 + N_RAND + 32 + 1;
    localparam int CYCLE_LIMIT = N_TESTS * (PROG_LEN * 40 + 150);

    logic        CLK;
    logic        nRST;
    logic        ibus_cyc, ibus_stb, ibus_ack;
    logic [31:0] ibus_adr, ibus_rdata;
    logic        dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    logic [31:0] dbus_adr, dbus_wdata, dbus_rdata;
    logic [3:0]  dbus_sel;
    logic        halted, fault;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] mram [256];
    logic [31:0] xr [32];
    logic [67:0] exp_wr [$];
    logic [31:0] seed, i_seed, d_seed;
    logic        stopped, exp_fault, i_busy, d_busy;
    int          i_wait, d_wait, n_instr, exp_reads, d_reads, xfers, n_wr;
    int          errors, cycles, n_pass, n_fail;

    core_top core_top_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_sel   (dbus_sel),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack),
        .halted     (halted),
        .fault      (fault)
    );

    always #2 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // every byte of the word depends on the word index
    function automatic logic [31:0] ram_fill(input int i);
        return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] ^ 8'hc3};
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic put(input logic [31:0] ins);
        rom[n_instr] = ins;
        n_instr++;
    endtask

    // model store with little-endian lanes and replicated data
    task automatic model_store(input logic [2:0] f3, input logic [31:0] a,
                               input logic [31:0] v);
        logic [3:0]  sel;
        logic [31:0] d;
        int          b;
        case (f3)
            3'b000: begin
                sel = 4'b0001 << a[1:0];
                d   = {4{v[7:0]}};
            end
            3'b001: begin
                sel = a[1] ? 4'b1100 : 4'b0011;
                d   = {2{v[15:0]}};
            end
            default: begin
                sel = 4'b1111;
                d   = v;
            end
        endcase
        for (b = 0; b < 4; b++) begin
            if (sel[b]) mram[a[9:2]][8*b +: 8] = d[8*b +: 8];
        end
        exp_wr.push_back({a, sel, d});
    endtask

    task automatic model_load(input logic [2:0] f3, input logic [31:0] a,
                              output logic [31:0] val);
        logic [31:0] lane;
        lane = mram[a[9:2]] >> (8 * a[1:0]);
        case (f3)
            3'b000:  val = {{24{lane[7]}}, lane[7:0]};
            3'b001:  val = {{16{lane[15]}}, lane[15:0]};
            3'b100:  val = {24'h0, lane[7:0]};
            3'b101:  val = {16'h0, lane[15:0]};
            default: val = lane;
        endcase
        exp_reads++;
    endtask

    // builds the program in rom and runs the model over it
    task automatic gen_program(input int t);
        int          r, k, offi;
        logic [31:0] v, w, res;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        n_instr = 0;
        exp_reads = 0;
        stopped = 1'b0;
        exp_fault = 1'b0;
        exp_wr.delete();
        for (r = 0; r < 256; r++) begin
            rom[r] = 32'h0010_0073;
            mram[r] = ram_fill(r);
        end
        xr[0] = '0;
        for (r = 1; r < 31; r++) begin
            v = next_rand();
            put({v[31:12], r[4:0], 7'b0110111});
            put(enc_i(v[11:0], r[4:0], 3'b000, r[4:0], 7'b0010011));
            xr[r] = {v[31:12], 12'h000} + {{20{v[11]}}, v[11:0]};
        end
        // x31 is the load/store base
        put(enc_i(12'h180, 5'd0, 3'b000, 5'd31, 7'b0010011));
        xr[31] = 32'h180;
        for (k = 0; k < N_RAND; k++) begin
            v = next_rand();
            w = next_rand();
            rd = (v[4:0] == 5'd31) ? 5'd0 : v[4:0];
            rs1 = v[9:5];
            rs2 = v[14:10];
            offi = int'(w[8:0]) - 256;
            if (t >= 4 && k == N_RAND / 2) begin
                // misaligned LH at base + 1 or SW at base + 2
                stopped = 1'b1;
                exp_fault = 1'b1;
                if (t == 4) put(enc_i(12'h001, 5'd31, 3'b001, 5'd5, 7'b0000011));
                else put(enc_s(12'h002, 5'd7, 5'd31, 3'b010));
            end else begin
                case (v[17:15])
                    3'd0, 3'd1, 3'd2: begin
                        f7 = 7'h00;
                        case (int'(w[2:0]) % 5)
                            0: begin
                                f3  = 3'b000;
                                res = xr[rs1] + xr[rs2];
                            end
                            1: begin
                                f3  = 3'b000;
                                f7  = 7'h20;
                                res = xr[rs1] - xr[rs2];
                            end
                            2: begin
                                f3  = 3'b100;
                                res = xr[rs1] ^ xr[rs2];
                            end
                            3: begin
                                f3  = 3'b110;
                                res = xr[rs1] | xr[rs2];
                            end
                            default: begin
                                f3  = 3'b111;
                                res = xr[rs1] & xr[rs2];
                            end
                        endcase
                        put(enc_r(f7, rs2, rs1, f3, rd));
                    end
                    3'd3: begin
                        put(enc_i(w[31:20], rs1, 3'b000, rd, 7'b0010011));
                        res = xr[rs1] + {{20{w[31]}}, w[31:20]};
                    end
                    3'd4: begin
                        put({w[31:12], rd, 7'b0110111});
                        res = {w[31:12], 12'h000};
                    end
                    3'd5, 3'd6: begin
                        case (int'(w[11:9]) % 5)
                            0: f3 = 3'b000;
                            1: f3 = 3'b001;
                            2: f3 = 3'b010;
                            3: f3 = 3'b100;
                            default: f3 = 3'b101;
                        endcase
                        if (f3 == 3'b010) offi = offi & ~3;
                        if (f3[1:0] == 2'b01) offi = offi & ~1;
                        put(enc_i(offi[11:0], 5'd31, f3, rd, 7'b0000011));
                        if (!stopped) model_load(f3, 32'h180 + offi, res);
                    end
                    default: begin
                        f3 = 3'(int'(w[10:9]) % 3);
                        if (f3 == 3'b010) offi = offi & ~3;
                        if (f3 == 3'b001) offi = offi & ~1;
                        put(enc_s(offi[11:0], rs2, 5'd31, f3));
                        if (!stopped) model_store(f3, 32'h180 + offi, xr[rs2]);
                        rd = 5'd0;
                    end
                endcase
                if (!stopped && rd != 5'd0) xr[rd] = res;
            end
        end
        // dump every register including x0
        for (r = 0; r < 32; r++) begin
            put(enc_s(12'h200 + 12'(4 * r), r[4:0], 5'd0, 3'b010));
            if (!stopped) model_store(3'b010, 32'h200 + 4 * r, xr[r]);
        end
        put(32'h0010_0073);
    endtask

    task automatic serve_data();
        logic [67:0] e;
        int          b;
        if (dbus_adr[31:10] != 22'h0) begin
            $display("data access outside the RAM at address %h", dbus_adr);
            errors++;
        end
        if (!dbus_we) begin
            dbus_rdata = ram[dbus_adr[9:2]];
            d_reads++;
        end else begin
            if (exp_wr.size() == 0) begin
                $display("unexpected data write to %h", dbus_adr);
                errors++;
            end else begin
                e = exp_wr.pop_front();
                n_wr++;
                if (dbus_adr !== e[67:36]) begin
                    $display("MISMATCH dbus_adr: expected %h, got %h", e[67:36], dbus_adr);
                    errors++;
                end
                if (dbus_sel !== e[35:32]) begin
                    $display("MISMATCH dbus_sel: expected %h, got %h", e[35:32], dbus_sel);
                    errors++;
                end
                if (dbus_wdata !== e[31:0]) begin
                    $display("MISMATCH dbus_wdata: expected %h, got %h", e[31:0], dbus_wdata);
                    errors++;
                end
            end
            for (b = 0; b < 4; b++) begin
                if (dbus_sel[b]) ram[dbus_adr[9:2]][8*b +: 8] = dbus_wdata[8*b +: 8];
            end
        end
    endtask

    // instruction slave with 0 to 3 wait cycles before a single ack
    always begin
        @(posedge CLK);
        #0.5;
        if (nRST && (ibus_cyc !== ibus_stb)) begin
            $display("instruction bus cyc and stb are not raised and dropped together");
            errors++;
        end
        if (!nRST || ibus_ack) begin
            if (nRST && ibus_cyc) begin
                $display("instruction bus cycle still open in the cycle after ack");
                errors++;
            end
            ibus_ack = 1'b0;
            i_busy = 1'b0;
        end else if (ibus_stb) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_seed = xorshift(i_seed);
                i_wait = int'(i_seed[1:0]);
            end
            if (i_wait != 0) begin
                i_wait--;
            end else begin
                ibus_ack = 1'b1;
                ibus_rdata = rom[ibus_adr[9:2]];
            end
        end
    end

    // data slave
    always begin
        @(posedge CLK);
        #0.5;
        if (nRST && (dbus_cyc !== dbus_stb)) begin
            $display("data bus cyc and stb are not raised and dropped together");
            errors++;
        end
        if (!nRST || dbus_ack) begin
            if (nRST && dbus_cyc) begin
                $display("data bus cycle still open in the cycle after ack");
                errors++;
            end
            dbus_ack = 1'b0;
            d_busy = 1'b0;
        end else if (dbus_stb) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_seed = xorshift(d_seed);
                d_wait = int'(d_seed[1:0]);
            end
            if (d_wait != 0) begin
                d_wait--;
            end else begin
                dbus_ack = 1'b1;
                xfers++;
                serve_data();
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core never halted", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic run_test(input int t);
        int err0, xfer0, r;
        @(posedge CLK);
        #0.5;
        nRST = 1'b0;
        gen_program(t);
        for (r = 0; r < 256; r++) ram[r] = ram_fill(r);
        d_reads = 0;
        n_wr = 0;
        err0 = errors;
        repeat (5) @(posedge CLK);
        #0.5;
        nRST = 1'b1;
        while (!halted) begin
            @(posedge CLK);
            #1;
        end
        xfer0 = xfers;
        repeat (100) @(posedge CLK);
        #1;
        if (fault !== exp_fault) begin
            $display("MISMATCH fault: expected %h, got %h", exp_fault, fault);
            errors++;
        end
        if (halted !== 1'b1) begin
            $display("halted dropped after the core stopped");
            errors++;
        end
        if (xfers != xfer0) begin
            $display("data bus transfer seen after the core halted");
            errors++;
        end
        if (exp_wr.size() != 0) begin
            $display("%0d expected data writes never happened", exp_wr.size());
            errors++;
        end
        if (d_reads != exp_reads) begin
            $display("MISMATCH read_count: expected %h, got %h", exp_reads, d_reads);
            errors++;
        end
        if (errors == err0) n_pass++;
        else n_fail++;
        $display("test %0d %s: %0d instructions, %0d data writes, fault %0d", t,
                 (errors == err0) ? "ok" : "bad", n_instr, n_wr, fault);
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        ibus_ack = 1'b0;
        ibus_rdata = '0;
        dbus_ack = 1'b0;
        dbus_rdata = '0;
        seed = 32'h44662936;
        i_seed = seed ^ 32'h0f0f_1357;
        d_seed = seed ^ 32'h7531_f0f0;
        errors = 0;
        cycles = 0;
        xfers = 0;
        n_pass = 0;
        n_fail = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/core_top.sv
/*
 * rv core top level
 * fetch stage, instruction queue and execute stage on two
 * Wishbone classic master ports
 */

`timescale 1ns/10ps

`include "rv_core_config.svh"

module core_top (
    input  logic                  CLK,
    input  logic                  nRST,
    output logic                  ibus_cyc,
    output logic                  ibus_stb,
    output rv_core_pkg::word_t    ibus_adr,
    input  rv_core_pkg::word_t    ibus_rdata,
    input  logic                  ibus_ack,
    output logic                  dbus_cyc,
    output logic                  dbus_stb,
    output logic                  dbus_we,
    output rv_core_pkg::word_t    dbus_adr,
    output logic [`RV_XLEN/8-1:0] dbus_sel,
    output rv_core_pkg::word_t    dbus_wdata,
    input  rv_core_pkg::word_t    dbus_rdata,
    input  logic                  dbus_ack,
    output logic                  halted,
    output logic                  fault
);

    logic                    push_valid;
    logic                    push_ready;
    rv_core_pkg::fetch_pkt_t push_pkt;
    logic                    pop_valid;
    logic                    pop_ready;
    rv_core_pkg::fetch_pkt_t pop_pkt;

    fetch_stage fetch_stage_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .push_valid (push_valid),
        .push_pkt   (push_pkt),
        .push_ready (push_ready)
    );

    instr_queue #(
        .payload_t (rv_core_pkg::fetch_pkt_t),
        .DEPTH     (`RV_QUEUE_DEPTH)
    ) instr_queue_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .push_valid (push_valid),
        .push_pkt   (push_pkt),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_pkt    (pop_pkt),
        .pop_ready  (pop_ready)
    );

    execute_stage execute_stage_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .pop_valid  (pop_valid),
        .pop_pkt    (pop_pkt),
        .pop_ready  (pop_ready),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_sel   (dbus_sel),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack),
        .halted     (halted),
        .fault      (fault)
    );

endmodule

// File: verilog/execute_stage.sv
/*
 * execute stage
 * decodes the queue head, runs the ALU and the register file, and does
 * loads and stores as a Wishbone classic data master. EBREAK, unknown
 * opcodes and misaligned accesses stop the core.
 */

`timescale 1ns/10ps

`include "rv_core_config.svh"

module execute_stage (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      pop_valid,
    input  rv_core_pkg::fetch_pkt_t   pop_pkt,
    output logic                      pop_ready,
    output logic                      dbus_cyc,
    output logic                      dbus_stb,
    output logic                      dbus_we,
    output rv_core_pkg::word_t        dbus_adr,
    output logic [`RV_XLEN/8-1:0]     dbus_sel,
    output rv_core_pkg::word_t        dbus_wdata,
    input  rv_core_pkg::word_t        dbus_rdata,
    input  logic                      dbus_ack,
    output logic                      halted,
    output logic                      fault
);

    rv_core_pkg::word_t   instr;
    rv_core_pkg::opcode_t opcode;
    rv_core_pkg::access_t access;
    logic [2:0]           funct3;
    logic [4:0]           rd;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    rv_core_pkg::word_t   imm_i;
    rv_core_pkg::word_t   imm_s;
    rv_core_pkg::word_t   imm_u;
    rv_core_pkg::word_t   rs1_data;
    rv_core_pkg::word_t   rs2_data;

    logic is_alu, is_alui, is_lui, is_load, is_store, is_stop;
    logic alu_ok, acc_ok, mem_op, stop_op, misaligned, go, halt_now, ack_gap;
    logic wr_en;

    rv_core_pkg::word_t alu_b;
    rv_core_pkg::word_t alu_res;
    rv_core_pkg::word_t mem_addr;
    rv_core_pkg::word_t load_lane;
    rv_core_pkg::word_t load_val;
    rv_core_pkg::word_t wr_data;

    assign instr  = pop_pkt.instr;
    assign opcode = rv_core_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign access = rv_core_pkg::access_t'(funct3);
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u  = {instr[31:12], 12'h000};

    reg_file reg_file_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (rd),
        .wr_data  (wr_data)
    );

    // OP_SYSTEM and any unknown opcode halt the core
    always_comb begin
        is_alu   = 1'b0;
        is_alui  = 1'b0;
        is_lui   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_stop  = 1'b0;
        case (opcode)
            rv_core_pkg::OP_ALU:   is_alu   = 1'b1;
            rv_core_pkg::OP_ALUI:  is_alui  = 1'b1;
            rv_core_pkg::OP_LUI:   is_lui   = 1'b1;
            rv_core_pkg::OP_LOAD:  is_load  = 1'b1;
            rv_core_pkg::OP_STORE: is_store = 1'b1;
            default:               is_stop  = 1'b1;
        endcase
    end

    // unsupported ALU functions retire without a write
    assign alu_ok = (is_alu && (funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}))
                  || (is_alui && (funct3 == 3'b000));

    assign acc_ok = is_load ? (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                            : (funct3 inside {3'b000, 3'b001, 3'b010});
    assign mem_op  = (is_load || is_store) && acc_ok;
    assign stop_op = is_stop || ((is_load || is_store) && !acc_ok);

    assign alu_b = is_alu ? rs2_data : imm_i;

    always_comb begin
        case (funct3)
            3'b100:  alu_res = rs1_data ^ alu_b;
            3'b110:  alu_res = rs1_data | alu_b;
            3'b111:  alu_res = rs1_data & alu_b;
            default: alu_res = (is_alu && instr[30]) ? rs1_data - alu_b : rs1_data + alu_b;
        endcase
    end

    assign mem_addr = rs1_data + (is_store ? imm_s : imm_i);

    // loads and stores share the funct3 size encoding
    always_comb begin
        case (access)
            rv_core_pkg::LB, rv_core_pkg::LBU: dbus_sel = 4'b0001 << mem_addr[1:0];
            rv_core_pkg::LH, rv_core_pkg::LHU: dbus_sel = mem_addr[1] ? 4'b1100 : 4'b0011;
            rv_core_pkg::LW:                   dbus_sel = 4'b1111;
            default:                           dbus_sel = 4'b0000;
        endcase
    end

    always_comb begin
        case (access)
            rv_core_pkg::LB: dbus_wdata = {4{rs2_data[7:0]}};
            rv_core_pkg::LH: dbus_wdata = {2{rs2_data[15:0]}};
            default:         dbus_wdata = rs2_data;
        endcase
    end

    always_comb begin
        case (access)
            rv_core_pkg::LH, rv_core_pkg::LHU: misaligned = mem_addr[0];
            rv_core_pkg::LW:                   misaligned = (mem_addr[1:0] != 2'b00);
            default:                           misaligned = 1'b0;
        endcase
    end

    // little-endian lane shifted down to bit 0, then extended
    assign load_lane = dbus_rdata >> {mem_addr[1:0], 3'b000};

    always_comb begin
        case (access)
            rv_core_pkg::LB:  load_val = {{24{load_lane[7]}}, load_lane[7:0]};
            rv_core_pkg::LBU: load_val = {24'h000000, load_lane[7:0]};
            rv_core_pkg::LH:  load_val = {{16{load_lane[15]}}, load_lane[15:0]};
            rv_core_pkg::LHU: load_val = {16'h0000, load_lane[15:0]};
            default:          load_val = dbus_rdata;
        endcase
    end

    assign go       = pop_valid && !halted;
    assign halt_now = go && (stop_op || (mem_op && misaligned));

    // ack_gap keeps cyc low for one cycle after each ack
    assign dbus_cyc = go && mem_op && !misaligned && !ack_gap;
    assign dbus_stb = dbus_cyc;
    assign dbus_we  = dbus_cyc && is_store;
    assign dbus_adr = mem_addr;

    assign pop_ready = go && ((dbus_cyc && dbus_ack) || (!mem_op && !stop_op));

    assign wr_en   = pop_ready && (alu_ok || is_lui || is_load);
    assign wr_data = is_load ? load_val : (is_lui ? imm_u : alu_res);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halted  <= 1'b0;
            fault   <= 1'b0;
            ack_gap <= 1'b0;
        end else begin
            ack_gap <= dbus_cyc && dbus_ack;
            if (halt_now) begin
                halted <= 1'b1;
                fault  <= mem_op && misaligned;
            end
        end
    end

    a_sel_nonzero: assert property (
        @(posedge CLK) disable iff (!nRST) dbus_stb |-> (dbus_sel != '0)
    );

    // the instruction that stops the core stays at the head
    a_no_pop_halted: assert property (
        @(posedge CLK) disable iff (!nRST) halt_now |-> !pop_ready
    );

endmodule

// File: verilog/reg_file.sv
/*
 * integer register file
 * 32 x 32, two combinational read ports, one write port, x0 reads zero
 */

`timescale 1ns/10ps

module reg_file (
    input  logic               CLK,
    input  logic               nRST,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    output rv_core_pkg::word_t rs1_data,
    output rv_core_pkg::word_t rs2_data,
    input  logic               wr_en,
    input  logic [4:0]         wr_addr,
    input  rv_core_pkg::word_t wr_data
);

    // x1..x31, x0 has no storage
    rv_core_pkg::word_t regs [1:31];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/instr_queue.sv
/*
 * instruction queue
 * synchronous FIFO with a valid/ready handshake on both sides,
 * head entry shown combinationally on pop_pkt
 */

`timescale 1ns/10ps

`include "rv_core_config.svh"

module instr_queue #(
    parameter type         payload_t = rv_core_pkg::fetch_pkt_t,
    parameter int unsigned DEPTH     = `RV_QUEUE_DEPTH
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     push_valid,
    input  payload_t push_pkt,
    output logic     push_ready,
    output logic     pop_valid,
    output payload_t pop_pkt,
    input  logic     pop_ready
);

    localparam int unsigned AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          do_push;
    logic          do_pop;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign pop_pkt    = mem[rd_ptr[AW-1:0]];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_pkt;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // fetch has no retry, an offer into a full queue would lose an instruction
    a_no_push_full: assert property (
        @(posedge CLK) disable iff (!nRST) push_valid |-> !full
    );

    // execute only takes the head once it is there
    a_no_pop_empty: assert property (
        @(posedge CLK) disable iff (!nRST) pop_ready |-> !empty
    );

endmodule

// File: verilog/fetch_stage.sv
/*
 * fetch stage
 * Wishbone classic instruction master, reads one word per transfer
 * and pushes the pc/instruction pair into the instruction queue
 */

`timescale 1ns/10ps

`include "rv_core_config.svh"

module fetch_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output rv_core_pkg::word_t      ibus_adr,
    input  rv_core_pkg::word_t      ibus_rdata,
    input  logic                    ibus_ack,
    output logic                    push_valid,
    output rv_core_pkg::fetch_pkt_t push_pkt,
    input  logic                    push_ready
);

    localparam int unsigned INSTR_BYTES = `RV_XLEN / 8;

    rv_core_pkg::word_t pc;
    logic               busy;

    // pc only counts up, no redirects in this core
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc   <= `RV_RESET_PC;
            busy <= 1'b0;
        end else if (busy) begin
            if (ibus_ack) begin
                pc   <= pc + INSTR_BYTES;
                busy <= 1'b0;
            end
        end else if (push_ready) begin
            // idle for a cycle after each ack, then start if the queue has room
            busy <= 1'b1;
        end
    end

    assign ibus_cyc = busy;
    assign ibus_stb = busy;
    assign ibus_adr = pc;

    // queue cannot fill during a transfer, so the ack edge is also the push edge
    assign push_valid     = busy && ibus_ack;
    assign push_pkt.pc    = pc;
    assign push_pkt.instr = ibus_rdata;

    // address held until the slave acks
    a_adr_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (ibus_stb && !ibus_ack) |=> (ibus_stb && $stable(ibus_adr))
    );

endmodule

// File: verilog/rv_core_pkg.sv
/*
 * rv core shared types
 * data word, RV32I opcodes of the supported subset, load/store sizes
 * and the fetch packet carried by the instruction queue
 */

package rv_core_pkg;

    typedef logic [31:0] word_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 of loads, stores use LB, LH and LW
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } access_t;

    // one fetched instruction and its address
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

endpackage

// File: verilog/rv_core_config.svh
/*
 * rv core configuration
 * reset vector, instruction queue depth and datapath width
 */

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// queue entries, power of two and at least 2
`define RV_QUEUE_DEPTH 4

// data and address width
`define RV_XLEN 32

`endif
